// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_exec_mem_pipe
FILELIST  ?= exec_mem_pipe.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= PASS: all tests

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: alu.sv
`timescale 1ns/1ps

module alu (
    input  rv_exe_pkg::alu_op_t          op,
    input  logic                         res_sext,
    input  logic [rv_exe_pkg::XLEN-1:0]  src1,
    input  logic [rv_exe_pkg::XLEN-1:0]  src2,
    output logic [rv_exe_pkg::XLEN-1:0]  result,
    output logic [rv_exe_pkg::XLEN-1:0]  sum
);

    localparam int XLEN = rv_exe_pkg::XLEN;

    logic [XLEN-1:0]       diff;
    logic [5:0]            sh;
    logic [XLEN-1:0]       sra_src;
    logic                  src1_neg;
    logic                  src2_neg;
    logic signed [2*XLEN+1:0] prod;
    logic [XLEN-1:0]       raw;

    assign sum  = src1 + src2;
    assign diff = src1 - src2;
    assign sh   = src2[5:0];

    // Word sra needs the sign of bit 31, operand arrives zero-extended
    assign sra_src = res_sext ? {{(XLEN-32){src1[31]}}, src1[31:0]} : src1;

    // ----------------------------------------
    // Multiplier, one extra bit per operand
    // ----------------------------------------
    assign src1_neg = !op.mul_u && src1[XLEN-1];
    assign src2_neg = !op.mul_u && !op.mul_su && src2[XLEN-1];
    assign prod     = $signed({src1_neg, src1}) * $signed({src2_neg, src2});

    always_comb begin
        raw = '0;
        if (op.op_add) begin
            raw = sum;
        end else if (op.op_sub) begin
            raw = diff;
        end else if (op.op_slt) begin
            raw = {{(XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
        end else if (op.op_sltu) begin
            raw = {{(XLEN-1){1'b0}}, src1 < src2};
        end else if (op.op_and) begin
            raw = src1 & src2;
        end else if (op.op_or) begin
            raw = src1 | src2;
        end else if (op.op_xor) begin
            raw = src1 ^ src2;
        end else if (op.op_sll) begin
            raw = src1 << sh;
        end else if (op.op_srl) begin
            raw = src1 >> sh;
        end else if (op.op_sra) begin
            raw = $signed(sra_src) >>> sh;
        end else if (op.op_mul) begin
            // High half for mulh, mulhsu, mulhu
            raw = op.mul_h ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];
        end
    end

    // Word forms keep the low 32 bits, sign-extended
    assign result = res_sext ? {{(XLEN-32){raw[31]}}, raw[31:0]} : raw;

endmodule

// File: data_sram.sv
`timescale 1ns/1ps

module data_sram #(
    parameter int SRAM_DEPTH = 256
) (
    input  logic                         clk,
    input  logic                         en,
    input  logic [7:0]                   wen,
    input  logic [rv_exe_pkg::XLEN-1:0]  addr,
    input  logic [rv_exe_pkg::XLEN-1:0]  wdata,
    output logic [rv_exe_pkg::XLEN-1:0]  rdata
);

    localparam int AW = $clog2(SRAM_DEPTH);

    logic [rv_exe_pkg::XLEN-1:0] mem [SRAM_DEPTH];
    logic [AW-1:0]               idx;

    // Word index, bits 2:0 select the byte
    assign idx = addr[AW+2:3];

    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < 8; i++) begin
                if (wen[i]) begin
                    mem[idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
            // Read data held until the next enable
            rdata <= mem[idx];
        end
    end

endmodule

// File: exe_stage.sv
`timescale 1ns/1ps

module exe_stage (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         ds_to_es_valid,
    input  rv_exe_pkg::decode_bus_t      ds_to_es_bus,
    input  logic                         ms_allowin,
    output logic                         es_allowin,
    output logic                         es_to_ms_valid,
    output rv_exe_pkg::exe_bus_t         es_to_ms_bus,
    output logic                         mem_en,
    output logic [7:0]                   mem_wen,
    output logic [rv_exe_pkg::XLEN-1:0]  mem_addr,
    output logic [rv_exe_pkg::XLEN-1:0]  mem_wdata,
    output rv_exe_pkg::fwd_bus_t         es_forward
);

    localparam int XLEN = rv_exe_pkg::XLEN;

    logic                     es_valid;
    logic                     es_go;
    rv_exe_pkg::decode_bus_t  ds_bus_r;
    logic                     is_shift;
    logic                     word_shift;
    logic [XLEN-1:0]          alu_src1;
    logic [XLEN-1:0]          alu_src2;
    logic [XLEN-1:0]          alu_result;
    logic [7:0]               size_mask;

    // ----------------------------------------
    // Pipeline register and handshake
    // ----------------------------------------
    assign es_allowin     = !es_valid || ms_allowin;
    assign es_to_ms_valid = es_valid;
    assign es_go          = es_to_ms_valid && ms_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_to_es_valid && es_allowin) begin
            ds_bus_r <= ds_to_es_bus;
        end
    end

    // ----------------------------------------
    // Operand selection
    // ----------------------------------------
    assign is_shift   = ds_bus_r.alu_op.op_sll || ds_bus_r.alu_op.op_srl ||
                        ds_bus_r.alu_op.op_sra;
    assign word_shift = ds_bus_r.res_sext && is_shift;

    assign alu_src1 = ds_bus_r.src_sel.src_pc ? ds_bus_r.pc :
                      ds_bus_r.src_sel.src_0  ? '0 :
                      word_shift ? {{(XLEN-32){1'b0}}, ds_bus_r.rs1_value[31:0]} :
                      ds_bus_r.rs1_value;

    assign alu_src2 = ds_bus_r.src_sel.src_4 ? XLEN'(4) :
                      ds_bus_r.src_sel.src_imm_u ?
                          {{(XLEN-32){ds_bus_r.imm_u[19]}}, ds_bus_r.imm_u, 12'b0} :
                      ds_bus_r.src_sel.src_imm_i ?
                          {{(XLEN-12){ds_bus_r.imm_i[11]}}, ds_bus_r.imm_i} :
                      ds_bus_r.src_sel.src_imm_s ?
                          {{(XLEN-12){ds_bus_r.imm_s[11]}}, ds_bus_r.imm_s} :
                      ds_bus_r.src_sel.src_shamt ? {{(XLEN-6){1'b0}}, ds_bus_r.shamt} :
                      word_shift ? {{(XLEN-5){1'b0}}, ds_bus_r.rs2_value[4:0]} :
                      is_shift ? {{(XLEN-6){1'b0}}, ds_bus_r.rs2_value[5:0]} :
                      ds_bus_r.rs2_value;

    alu alu0 (
        .op       (ds_bus_r.alu_op),
        .res_sext (ds_bus_r.res_sext),
        .src1     (alu_src1),
        .src2     (alu_src2),
        .result   (alu_result),
        .sum      (mem_addr)
    );

    // ----------------------------------------
    // Memory request on hand-off only
    // ----------------------------------------
    always_comb begin
        case (ds_bus_r.mem_size)
            rv_exe_pkg::MEM_B: size_mask = 8'h01;
            rv_exe_pkg::MEM_H: size_mask = 8'h03;
            rv_exe_pkg::MEM_W: size_mask = 8'h0f;
            default:           size_mask = 8'hff;
        endcase
    end

    assign mem_en  = es_go && (ds_bus_r.mem_re || ds_bus_r.mem_we);
    assign mem_wen = (es_go && ds_bus_r.mem_we) ? size_mask << mem_addr[2:0] : 8'h00;

    // Same data in every lane so the strobes pick the lane
    always_comb begin
        case (ds_bus_r.mem_size)
            rv_exe_pkg::MEM_B: mem_wdata = {8{ds_bus_r.rs2_value[7:0]}};
            rv_exe_pkg::MEM_H: mem_wdata = {4{ds_bus_r.rs2_value[15:0]}};
            rv_exe_pkg::MEM_W: mem_wdata = {2{ds_bus_r.rs2_value[31:0]}};
            default:           mem_wdata = ds_bus_r.rs2_value;
        endcase
    end

    always_comb begin
        es_to_ms_bus.res_sext = ds_bus_r.res_sext;
        es_to_ms_bus.res_zext = ds_bus_r.res_zext;
        es_to_ms_bus.mem_size = ds_bus_r.mem_size;
        es_to_ms_bus.mem_re   = ds_bus_r.mem_re;
        es_to_ms_bus.rf_we    = ds_bus_r.rf_we;
        es_to_ms_bus.rd       = ds_bus_r.rd;
        es_to_ms_bus.result   = alu_result;
        es_to_ms_bus.pc       = ds_bus_r.pc;
    end

    // Forwarded value is only an address while a load is pending
    assign es_forward.load_pending = es_valid && ds_bus_r.mem_re;
    assign es_forward.valid        = es_valid && ds_bus_r.rf_we;
    assign es_forward.value        = alu_result;
    assign es_forward.rd           = ds_bus_r.rd;

endmodule

// File: exec_mem_pipe.f
rv_exe_pkg.sv
alu.sv
exe_stage.sv
mem_stage.sv
data_sram.sv
exec_mem_pipe.sv
tb_exec_mem_pipe.sv

// File: exec_mem_pipe.sv
`timescale 1ns/1ps

module exec_mem_pipe #(
    parameter int SRAM_DEPTH = 256
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     ds_to_es_valid,
    input  rv_exe_pkg::decode_bus_t  ds_to_es_bus,
    input  logic                     ws_allowin,
    output logic                     es_allowin,
    output logic                     ms_to_ws_valid,
    output rv_exe_pkg::wb_bus_t      ms_to_ws_bus,
    output rv_exe_pkg::fwd_bus_t     es_forward,
    output rv_exe_pkg::fwd_bus_t     ms_forward
);

    logic                         ms_allowin;
    logic                         es_to_ms_valid;
    rv_exe_pkg::exe_bus_t         es_to_ms_bus;

    // Data memory port
    logic                         mem_en;
    logic [7:0]                   mem_wen;
    logic [rv_exe_pkg::XLEN-1:0]  mem_addr;
    logic [rv_exe_pkg::XLEN-1:0]  mem_wdata;
    logic [rv_exe_pkg::XLEN-1:0]  mem_rdata;

    exe_stage exe_stage0 (
        .clk            (clk),
        .reset          (reset),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .ms_allowin     (ms_allowin),
        .es_allowin     (es_allowin),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .mem_en         (mem_en),
        .mem_wen        (mem_wen),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .es_forward     (es_forward)
    );

    mem_stage mem_stage0 (
        .clk            (clk),
        .reset          (reset),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .mem_rdata      (mem_rdata),
        .ws_allowin     (ws_allowin),
        .ms_allowin     (ms_allowin),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .ms_forward     (ms_forward)
    );

    data_sram #(
        .SRAM_DEPTH (SRAM_DEPTH)
    ) data_sram0 (
        .clk   (clk),
        .en    (mem_en),
        .wen   (mem_wen),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

// File: mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         es_to_ms_valid,
    input  rv_exe_pkg::exe_bus_t         es_to_ms_bus,
    input  logic [rv_exe_pkg::XLEN-1:0]  mem_rdata,
    input  logic                         ws_allowin,
    output logic                         ms_allowin,
    output logic                         ms_to_ws_valid,
    output rv_exe_pkg::wb_bus_t          ms_to_ws_bus,
    output rv_exe_pkg::fwd_bus_t         ms_forward
);

    localparam int XLEN = rv_exe_pkg::XLEN;

    logic                  ms_valid;
    rv_exe_pkg::exe_bus_t  es_bus_r;
    logic [XLEN-1:0]       lane;
    logic                  sign_ext;
    logic [XLEN-1:0]       load_value;
    logic [XLEN-1:0]       ms_wdata;

    // ----------------------------------------
    // Pipeline register and handshake
    // ----------------------------------------
    assign ms_allowin     = !ms_valid || ws_allowin;
    assign ms_to_ws_valid = ms_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid && ms_allowin) begin
            es_bus_r <= es_to_ms_bus;
        end
    end

    // ----------------------------------------
    // Load alignment and extension
    // ----------------------------------------
    // Move the addressed byte down to lane 0
    assign lane     = mem_rdata >> {es_bus_r.result[2:0], 3'b000};
    assign sign_ext = !es_bus_r.res_zext;

    always_comb begin
        case (es_bus_r.mem_size)
            rv_exe_pkg::MEM_B:
                load_value = {{(XLEN-8){sign_ext && lane[7]}}, lane[7:0]};
            rv_exe_pkg::MEM_H:
                load_value = {{(XLEN-16){sign_ext && lane[15]}}, lane[15:0]};
            rv_exe_pkg::MEM_W:
                load_value = {{(XLEN-32){sign_ext && lane[31]}}, lane[31:0]};
            default:
                load_value = lane;
        endcase
    end

    assign ms_wdata = es_bus_r.mem_re ? load_value : es_bus_r.result;

    assign ms_to_ws_bus.rf_we = es_bus_r.rf_we;
    assign ms_to_ws_bus.rd    = es_bus_r.rd;
    assign ms_to_ws_bus.wdata = ms_wdata;
    assign ms_to_ws_bus.pc    = es_bus_r.pc;

    // Load data is already final in this stage
    assign ms_forward.load_pending = 1'b0;
    assign ms_forward.valid        = ms_valid && es_bus_r.rf_we;
    assign ms_forward.value        = ms_wdata;
    assign ms_forward.rd           = es_bus_r.rd;

endmodule

// File: rv_exe_pkg.sv
package rv_exe_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int XLEN  = 64;
    localparam int PC_WD = 64;

    // One flag per ALU operation, at most one op_* set at a time
    typedef struct packed {
        logic mul_u;
        logic mul_su;
        logic mul_h;
        logic op_mul;
        logic op_add;
        logic op_sub;
        logic op_slt;
        logic op_sltu;
        logic op_and;
        logic op_or;
        logic op_xor;
        logic op_sll;
        logic op_srl;
        logic op_sra;
    } alu_op_t;

    // Operand source flags
    typedef struct packed {
        logic src_shamt;
        logic src_pc;
        logic src_imm_u;
        logic src_4;
        logic src_0;
        logic src_imm_i;
        logic src_imm_s;
    } src_sel_t;

    typedef enum logic [1:0] {
        MEM_B = 2'd0,
        MEM_H = 2'd1,
        MEM_W = 2'd2,
        MEM_D = 2'd3
    } mem_size_t;

    // ----------------------------------------
    // Inter-stage records
    // ----------------------------------------
    typedef struct packed {
        alu_op_t           alu_op;
        logic              res_sext;
        logic              res_zext;
        logic [5:0]        shamt;
        src_sel_t          src_sel;
        logic              rf_we;
        logic              mem_we;
        logic              mem_re;
        mem_size_t         mem_size;
        logic [4:0]        rd;
        logic [11:0]       imm_s;
        logic [11:0]       imm_i;
        logic [19:0]       imm_u;
        logic [XLEN-1:0]   rs1_value;
        logic [XLEN-1:0]   rs2_value;
        logic [PC_WD-1:0]  pc;
    } decode_bus_t;

    typedef struct packed {
        logic              res_sext;
        logic              res_zext;
        mem_size_t         mem_size;
        logic              mem_re;
        logic              rf_we;
        logic [4:0]        rd;
        logic [XLEN-1:0]   result;
        logic [PC_WD-1:0]  pc;
    } exe_bus_t;

    typedef struct packed {
        logic              rf_we;
        logic [4:0]        rd;
        logic [XLEN-1:0]   wdata;
        logic [PC_WD-1:0]  pc;
    } wb_bus_t;

    // load_pending only ever set by execute
    typedef struct packed {
        logic              load_pending;
        logic              valid;
        logic [XLEN-1:0]   value;
        logic [4:0]        rd;
    } fwd_bus_t;

endpackage

// File: tb_exec_mem_pipe.sv
`timescale 1ns/1ps

module tb_exec_mem_pipe;

    typedef enum logic [4:0] {
        K_ADD, K_SUB, K_SLT, K_SLTU, K_AND, K_OR, K_XOR, K_SLL, K_SRL, K_SRA,
        K_MUL, K_MULH, K_MULHSU, K_MULHU, K_ST, K_LD
    } kind_t;

    typedef enum logic [2:0] {S_REG, S_IMM, S_PC4, S_LUI, S_AUIPC, S_SHAMT} src_t;

    // One table row with operation, operand source, rs1, rs2, immediate and size
    typedef struct packed {
        kind_t        kind;
        logic         word;
        src_t         src;
        logic [63:0]  a;
        logic [63:0]  b;
        logic [19:0]  imm;
        logic [1:0]   size;
        logic         zext;
    } entry_t;

    typedef struct packed {
        rv_exe_pkg::wb_bus_t  wb;
        logic                 is_load;
    } exp_t;

    logic                     clk = 1'b0;
    logic                     reset = 1'b1;
    logic                     ds_to_es_valid = 1'b0;
    rv_exe_pkg::decode_bus_t  ds_to_es_bus = '0;
    logic                     ws_allowin = 1'b0;
    logic                     es_allowin;
    logic                     ms_to_ws_valid;
    rv_exe_pkg::wb_bus_t      ms_to_ws_bus;
    rv_exe_pkg::fwd_bus_t     es_forward;
    rv_exe_pkg::fwd_bus_t     ms_forward;

    int          seed = 67;
    entry_t      tests[$];
    exp_t        exp_q[$];
    logic [7:0]  shadow [0:2047];
    int          n_tests = 0;
    int          accepted = 0;
    int          retired = 0;
    int          cycle = 0;
    logic        started = 1'b0;
    logic        just_accepted = 1'b0;

    exec_mem_pipe #(
        .SRAM_DEPTH (256)
    ) dut0 (
        .clk            (clk),
        .reset          (reset),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .ws_allowin     (ws_allowin),
        .es_allowin     (es_allowin),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .es_forward     (es_forward),
        .ms_forward     (ms_forward)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "value check failed");
        end
    endtask

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic add_test(kind_t kind, logic word, src_t src, logic [63:0] a,
                            logic [63:0] b, logic [19:0] imm, logic [1:0] size, logic zext);
        tests.push_back(entry_t'{kind, word, src, a, b, imm, size, zext});
    endtask

    // ----------------------------------------
    // Decode record for one table row
    // ----------------------------------------
    function automatic rv_exe_pkg::decode_bus_t make_bus(entry_t e, int idx);
        rv_exe_pkg::decode_bus_t d;
        d = '0;
        d.alu_op.op_add  = (e.kind == K_ADD) || (e.kind == K_ST) || (e.kind == K_LD);
        d.alu_op.op_sub  = (e.kind == K_SUB);
        d.alu_op.op_slt  = (e.kind == K_SLT);
        d.alu_op.op_sltu = (e.kind == K_SLTU);
        d.alu_op.op_and  = (e.kind == K_AND);
        d.alu_op.op_or   = (e.kind == K_OR);
        d.alu_op.op_xor  = (e.kind == K_XOR);
        d.alu_op.op_sll  = (e.kind == K_SLL);
        d.alu_op.op_srl  = (e.kind == K_SRL);
        d.alu_op.op_sra  = (e.kind == K_SRA);
        d.alu_op.op_mul  = (e.kind >= K_MUL) && (e.kind <= K_MULHU);
        d.alu_op.mul_h   = (e.kind >= K_MULH) && (e.kind <= K_MULHU);
        d.alu_op.mul_su  = (e.kind == K_MULHSU);
        d.alu_op.mul_u   = (e.kind == K_MULHU);
        d.res_sext = e.word;
        d.res_zext = e.zext;
        d.shamt    = e.imm[5:0];
        d.src_sel.src_shamt = (e.src == S_SHAMT);
        d.src_sel.src_pc    = (e.src == S_PC4) || (e.src == S_AUIPC);
        d.src_sel.src_imm_u = (e.src == S_LUI) || (e.src == S_AUIPC);
        d.src_sel.src_4     = (e.src == S_PC4);
        d.src_sel.src_0     = (e.src == S_LUI);
        d.src_sel.src_imm_i = (e.src == S_IMM) || (e.kind == K_LD);
        d.src_sel.src_imm_s = (e.kind == K_ST);
        d.rf_we     = (e.kind != K_ST);
        d.mem_we    = (e.kind == K_ST);
        d.mem_re    = (e.kind == K_LD);
        d.mem_size  = rv_exe_pkg::mem_size_t'(e.size);
        d.rd        = 5'(idx % 31 + 1);
        d.imm_s     = e.imm[11:0];
        d.imm_i     = e.imm[11:0];
        d.imm_u     = e.imm;
        d.rs1_value = e.a;
        d.rs2_value = e.b;
        d.pc        = 64'h1000 + 64'(idx) * 64'd4;
        return d;
    endfunction

    // Reference model that also keeps the shadow memory up to date
    function automatic exp_t model_record(entry_t e, int idx);
        exp_t          r;
        logic [63:0]   pc;
        logic [63:0]   x;
        logic [63:0]   y;
        logic [63:0]   v;
        logic [31:0]   w32;
        logic [5:0]    sh;
        logic [127:0]  sx;
        logic [127:0]  sy;
        logic [127:0]  p;
        logic [10:0]   ba;
        logic          fill;
        int            nb;
        pc = 64'h1000 + 64'(idx) * 64'd4;
        if (e.src == S_PC4 || e.src == S_AUIPC) begin
            x = pc;
        end else if (e.src == S_LUI) begin
            x = '0;
        end else begin
            x = e.a;
        end
        case (e.src)
            S_PC4:         y = 64'd4;
            S_LUI, S_AUIPC: y = {{32{e.imm[19]}}, e.imm, 12'b0};
            S_IMM:         y = {{52{e.imm[11]}}, e.imm[11:0]};
            S_SHAMT:       y = {58'b0, e.imm[5:0]};
            default:       y = e.b;
        endcase
        if (e.kind == K_ST || e.kind == K_LD) begin
            y = {{52{e.imm[11]}}, e.imm[11:0]};
        end
        sh   = e.word ? {1'b0, y[4:0]} : y[5:0];
        sx   = (e.kind == K_MULHU) ? {64'b0, x} : {{64{x[63]}}, x};
        sy   = (e.kind == K_MULHU || e.kind == K_MULHSU) ? {64'b0, y} : {{64{y[63]}}, y};
        p    = sx * sy;
        w32  = $signed(x[31:0]) >>> sh;
        nb   = 1 << e.size;
        ba   = x[10:0] + y[10:0];
        v    = '0;
        case (e.kind)
            K_ADD:  v = x + y;
            K_SUB:  v = x - y;
            K_SLT:  v = 64'($signed(x) < $signed(y));
            K_SLTU: v = 64'(x < y);
            K_AND:  v = x & y;
            K_OR:   v = x | y;
            K_XOR:  v = x ^ y;
            K_SLL:  v = x << sh;
            K_SRL:  v = e.word ? {32'b0, x[31:0] >> sh} : x >> sh;
            K_SRA: begin
                if (e.word) begin
                    v = {32'b0, w32};
                end else begin
                    v = $signed(x) >>> sh;
                end
            end
            K_MUL:  v = p[63:0];
            K_MULH, K_MULHSU, K_MULHU: v = p[127:64];
            K_ST: begin
                v = x + y;
                for (int k = 0; k < nb; k++) begin
                    shadow[ba + 11'(k)] = e.b[8*k +: 8];
                end
            end
            default: begin
                for (int k = 0; k < nb; k++) begin
                    v[8*k +: 8] = shadow[ba + 11'(k)];
                end
                fill = !e.zext && v[8*nb-1];
                for (int k = nb; k < 8; k++) begin
                    v[8*k +: 8] = {8{fill}};
                end
            end
        endcase
        if (e.word) begin
            v = {{32{v[31]}}, v[31:0]};
        end
        r.wb.rf_we = (e.kind != K_ST);
        r.wb.rd    = 5'(idx % 31 + 1);
        r.wb.wdata = v;
        r.wb.pc    = pc;
        r.is_load  = (e.kind == K_LD);
        return r;
    endfunction

    task automatic build_tests();
        kind_t wk [5] = '{K_ADD, K_SUB, K_SLL, K_SRL, K_SRA};
        for (int k = K_ADD; k <= K_SRA; k++) begin
            add_test(kind_t'(k), 1'b0, S_REG, rand64(), rand64(), 20'd0, 2'd0, 1'b0);
        end
        add_test(K_SLT, 1'b0, S_REG, 64'hFFFF_FFFF_FFFF_FFFB, 64'd3, 20'd0, 2'd0, 1'b0);
        add_test(K_SLTU, 1'b0, S_REG, 64'hFFFF_FFFF_FFFF_FFFB, 64'd3, 20'd0, 2'd0, 1'b0);
        // Word forms
        foreach (wk[i]) begin
            add_test(wk[i], 1'b1, S_REG, rand64(), rand64(), 20'd0, 2'd0, 1'b0);
        end
        add_test(K_SRA, 1'b1, S_REG, 64'h0000_0000_8000_0010, 64'd4, 20'd0, 2'd0, 1'b0);
        // Immediate, shamt, pc and upper immediate sources
        for (int k = K_ADD; k <= K_XOR; k++) begin
            if (k != K_SUB) begin
                add_test(kind_t'(k), 1'b0, S_IMM, rand64(), 64'd0, 20'($random(seed)),
                         2'd0, 1'b0);
            end
        end
        for (int k = K_SLL; k <= K_SRA; k++) begin
            add_test(kind_t'(k), 1'b0, S_SHAMT, rand64(), 64'd0,
                     20'($random(seed)) & 20'h3f, 2'd0, 1'b0);
            add_test(kind_t'(k), 1'b1, S_SHAMT, rand64(), 64'd0,
                     20'($random(seed)) & 20'h1f, 2'd0, 1'b0);
        end
        add_test(K_ADD, 1'b0, S_PC4, rand64(), rand64(), 20'd0, 2'd0, 1'b0);
        add_test(K_ADD, 1'b0, S_LUI, rand64(), rand64(), 20'h80001, 2'd0, 1'b0);
        add_test(K_ADD, 1'b0, S_AUIPC, rand64(), rand64(), 20'h12345, 2'd0, 1'b0);
        // Multiplies with every sign mix
        for (int k = K_MUL; k <= K_MULHU; k++) begin
            add_test(kind_t'(k), 1'b0, S_REG, rand64(), rand64(), 20'd0, 2'd0, 1'b0);
            add_test(kind_t'(k), 1'b0, S_REG, '1, '1, 20'd0, 2'd0, 1'b0);
            add_test(kind_t'(k), 1'b0, S_REG, 64'h8000_0000_0000_0000,
                     64'h7FFF_FFFF_FFFF_FFFF, 20'd0, 2'd0, 1'b0);
            add_test(kind_t'(k), 1'b0, S_REG, 64'hFFFF_FFFF_FFFF_FFF9, 64'd3,
                     20'd0, 2'd0, 1'b0);
        end
        add_test(K_MUL, 1'b1, S_REG, rand64(), rand64(), 20'd0, 2'd0, 1'b0);
        // Store then load back at every size and aligned offset below the base
        for (int s = 0; s < 4; s++) begin
            for (int o = 0; o < 8; o += (1 << s)) begin
                add_test(K_ST, 1'b0, S_REG, 64'h240, rand64(), 20'(s * 8 + o - 32),
                         2'(s), 1'b0);
                add_test(K_LD, 1'b0, S_REG, 64'h240, 64'd0, 20'(s * 8 + o - 32),
                         2'(s), 1'b0);
                if (s < 3) begin
                    add_test(K_LD, 1'b0, S_REG, 64'h240, 64'd0, 20'(s * 8 + o - 32),
                             2'(s), 1'b1);
                end
            end
        end
    endtask

    // ----------------------------------------
    // Stimulus on the falling edge
    // ----------------------------------------
    initial begin
        build_tests();
        n_tests = tests.size();
        while (retired < n_tests) begin
            @(negedge clk);
            reset      = (cycle < 4);
            ws_allowin = (($random(seed) & 3) != 0);
            if (!reset && accepted < n_tests) begin
                ds_to_es_valid = (($random(seed) & 7) != 0);
                ds_to_es_bus   = make_bus(tests[accepted], accepted);
            end else begin
                ds_to_es_valid = 1'b0;
            end
        end
        repeat (2) @(negedge clk);
        $display("PASS: all tests");
        $finish;
    end

    // Monitor sees the values held since the last falling edge
    always @(posedge clk) begin
        exp_t  exe_rec;
        exp_t  ms_rec;
        exp_t  done_rec;
        logic  exe_full;
        logic  ms_full;
        if (started) begin
            // A lone record sits in execute only on the cycle after its acceptance
            exe_full = (exp_q.size() == 2) || (exp_q.size() == 1 && just_accepted);
            ms_full  = (exp_q.size() == 2) || (exp_q.size() == 1 && !just_accepted);
            exe_rec  = exe_full ? exp_q[exp_q.size() - 1] : '0;
            ms_rec   = ms_full ? exp_q[0] : '0;
            check_value("ms_to_ws_valid", 64'(ms_to_ws_valid), 64'(ms_full));
            check_value("es_allowin", 64'(es_allowin),
                        64'(!(exp_q.size() == 2 && !ws_allowin)));
            check_value("es_forward.valid", 64'(es_forward.valid),
                        64'(exe_full && exe_rec.wb.rf_we));
            check_value("es_forward.load_pending", 64'(es_forward.load_pending),
                        64'(exe_full && exe_rec.is_load));
            if (es_forward.valid) begin
                check_value("es_forward.rd", 64'(es_forward.rd), 64'(exe_rec.wb.rd));
            end
            if (es_forward.valid && !exe_rec.is_load) begin
                check_value("es_forward.value", es_forward.value, exe_rec.wb.wdata);
            end
            check_value("ms_forward.valid", 64'(ms_forward.valid),
                        64'(ms_full && ms_rec.wb.rf_we));
            check_value("ms_forward.load_pending", 64'(ms_forward.load_pending), 64'd0);
            if (ms_forward.valid) begin
                check_value("ms_forward.rd", 64'(ms_forward.rd), 64'(ms_rec.wb.rd));
                check_value("ms_forward.value", ms_forward.value, ms_rec.wb.wdata);
            end
            if (ms_to_ws_valid && ws_allowin) begin
                done_rec = exp_q.pop_front();
                check_value("wb rf_we", 64'(ms_to_ws_bus.rf_we), 64'(done_rec.wb.rf_we));
                check_value("wb rd", 64'(ms_to_ws_bus.rd), 64'(done_rec.wb.rd));
                check_value("wb wdata", ms_to_ws_bus.wdata, done_rec.wb.wdata);
                check_value("wb pc", ms_to_ws_bus.pc, done_rec.wb.pc);
                retired++;
            end
        end
        just_accepted = 1'b0;
        if (!reset && ds_to_es_valid && es_allowin) begin
            exp_q.push_back(model_record(tests[accepted], accepted));
            accepted++;
            just_accepted = 1'b1;
        end
        cycle++;
        started = 1'b1;
    end

    // Watchdog allows 20 cycles per table row
    initial begin
        wait (n_tests > 0);
        repeat (n_tests * 20 + 4) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, the pipeline stalled", cycle);
        $display("FAIL: see errors above");
        $fatal(1, "timeout");
    end

endmodule
